// ==== design/cdp_bufferin_pkg.sv ====
package cdp_bufferin_pkg;

  ////////////////////////////////
  // lane geometry
  ////////////////////////////////

  // one sliding channel window per width position
  localparam int NUM_LANES = 8;

  // channels per atomic group, last pos_c of a group is ATOMIC_C/TP - 1
  localparam int ATOMIC_C = 8;

  ////////////////////////////////
  // info field layout
  ////////////////////////////////

  // field widths
  localparam int POS_W_BITS = 4;
  localparam int WIDTH_BITS = 4;
  localparam int POS_C_BITS = 3;

  // bit offsets inside the info word that follows the data
  localparam int POS_W_LSB  = 0;
  localparam int WIDTH_LSB  = POS_W_LSB + POS_W_BITS;
  localparam int POS_C_LSB  = WIDTH_LSB + WIDTH_BITS;
  localparam int B_SYNC_BIT = POS_C_LSB + POS_C_BITS;
  localparam int LAST_W_BIT = B_SYNC_BIT + 1;
  localparam int LAST_H_BIT = LAST_W_BIT + 1;
  localparam int LAST_C_BIT = LAST_H_BIT + 1;

  // same 15-bit info word on the input and output payloads
  localparam int INFO_BITS  = LAST_C_BIT + 1;

endpackage

// ==== design/cdp_bufferin_if.sv ====
// shift command broadcast from ctrl to every lane
interface lane_shift_if
  import cdp_bufferin_pkg::*;
#(
  parameter int TP  = 2,
  parameter int BPE = 9
) ();
  // one-hot lane select, at most one lane shifts per step
  logic [NUM_LANES-1:0] shift_en;
  // new slot 0 content for the selected lane
  logic [TP*BPE-1:0]    shift_data;
  // flush shifts push zeros instead of shift_data
  logic                 zero_fill;
  // wipes every lane, pulses with the last flush step
  logic                 clear_all;

  modport ctrl (output shift_en, output shift_data, output zero_fill, output clear_all);
  modport lane (input shift_en, input shift_data, input zero_fill, input clear_all);
endinterface

// per-step info fields from ctrl to the output stage
interface beat_info_if
  import cdp_bufferin_pkg::*;
();
  // one pulse per output beat
  logic                  step;
  logic [POS_W_BITS-1:0] pos_w;
  // already reduced by one
  logic [WIDTH_BITS-1:0] width;
  logic [POS_C_BITS-1:0] pos_c;
  logic                  b_sync;
  logic                  last_w;
  logic                  last_h;
  logic                  last_c;

  modport ctrl (output step, pos_w, width, pos_c, b_sync, last_w, last_h, last_c);
  modport out (input step, pos_w, width, pos_c, b_sync, last_w, last_h, last_c);
endinterface

// ==== design/cdp_bufferin_ctrl.sv ====
module cdp_bufferin_ctrl
  import cdp_bufferin_pkg::*;
#(
  parameter int TP  = 2,
  parameter int BPE = 9
) (
  input  logic                         nvdla_core_clk,
  input  logic                         nvdla_core_rstn,
  input  logic [TP*BPE+INFO_BITS-1:0]  cdp_rdma2dp_pd,
  input  logic                         cdp_rdma2dp_valid,
  output logic                         cdp_rdma2dp_ready,
  input  logic                         out_free,
  lane_shift_if.ctrl                   lanes,
  beat_info_if.ctrl                    info
);

  localparam int DATA_BITS    = TP * BPE;
  localparam int PD_BITS      = DATA_BITS + INFO_BITS;
  // zero rounds needed so the trailing channels still see a full window
  localparam int FLUSH_ROUNDS = 4 / TP;
  localparam int ROUND_BITS   = (FLUSH_ROUNDS > 1) ? $clog2(FLUSH_ROUNDS) : 1;
  localparam int POS_C_END    = ATOMIC_C / TP - 1;

  // input register
  logic                  in_vld_q;
  logic [PD_BITS-1:0]    in_pd_q;
  // unpacked fields of the registered beat
  logic [DATA_BITS-1:0]  in_data;
  logic [INFO_BITS-1:0]  in_info;
  logic [POS_W_BITS-1:0] in_pos_w;
  logic [WIDTH_BITS-1:0] in_width_m1;
  logic [POS_C_BITS-1:0] in_pos_c;
  logic                  in_b_sync;
  logic                  in_last_w;
  logic                  in_last_h;
  logic                  in_last_c;
  logic                  cube_end;
  // flush sequencer
  logic                  flush_q;
  logic [POS_W_BITS-1:0] flush_pos_w_q;
  logic [ROUND_BITS-1:0] flush_round_q;
  logic                  round_end;
  logic                  flush_last;
  // fields held from the cube-end beat
  logic [WIDTH_BITS-1:0] hold_width_q;
  logic [POS_C_BITS-1:0] hold_pos_c_q;
  logic                  hold_last_w_q;
  logic                  hold_last_h_q;
  logic                  hold_last_c_q;
  // step qualifiers
  logic                  step_normal;
  logic                  flush_step;

  //////////////////////////////
  // input register and unpack
  //////////////////////////////

  // registered beat leaves when out can take it, never during flush
  assign step_normal = in_vld_q & out_free & ~flush_q;
  assign cdp_rdma2dp_ready = (~in_vld_q | step_normal) & ~flush_q;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      in_vld_q <= 1'b0;
    end else if (cdp_rdma2dp_valid && cdp_rdma2dp_ready) begin
      in_vld_q <= 1'b1;
    end else if (step_normal) begin
      in_vld_q <= 1'b0;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (cdp_rdma2dp_valid && cdp_rdma2dp_ready) begin
      in_pd_q <= cdp_rdma2dp_pd;
    end
  end

  assign in_data     = in_pd_q[DATA_BITS-1:0];
  assign in_info     = in_pd_q[DATA_BITS +: INFO_BITS];
  assign in_pos_w    = in_info[POS_W_LSB +: POS_W_BITS];
  // downstream expects width minus one
  assign in_width_m1 = in_info[WIDTH_LSB +: WIDTH_BITS] - WIDTH_BITS'(1);
  assign in_pos_c    = in_info[POS_C_LSB +: POS_C_BITS];
  assign in_b_sync   = in_info[B_SYNC_BIT];
  assign in_last_w   = in_info[LAST_W_BIT];
  assign in_last_h   = in_info[LAST_H_BIT];
  assign in_last_c   = in_info[LAST_C_BIT];

  // last channel group of the last line of the cube
  assign cube_end = in_b_sync & (in_pos_c == POS_C_BITS'(POS_C_END))
                  & in_last_w & in_last_h & in_last_c;

  //////////////////////////////
  // flush sequencer
  //////////////////////////////

  assign flush_step = flush_q & out_free;
  assign round_end  = (flush_round_q == ROUND_BITS'(FLUSH_ROUNDS - 1));
  assign flush_last = (flush_pos_w_q == hold_width_q) & round_end;

  // sweep pos_w 0..width-1, FLUSH_ROUNDS times
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      flush_q       <= 1'b0;
      flush_pos_w_q <= '0;
      flush_round_q <= '0;
    end else if (step_normal && cube_end) begin
      flush_q       <= 1'b1;
      flush_pos_w_q <= '0;
      flush_round_q <= '0;
    end else if (flush_step) begin
      if (flush_pos_w_q == hold_width_q) begin
        flush_pos_w_q <= '0;
        if (round_end) begin
          flush_q       <= 1'b0;
          flush_round_q <= '0;
        end else begin
          flush_round_q <= flush_round_q + ROUND_BITS'(1);
        end
      end else begin
        flush_pos_w_q <= flush_pos_w_q + POS_W_BITS'(1);
      end
    end
  end

  // info replayed on every flush step
  always_ff @(posedge nvdla_core_clk) begin
    if (step_normal && cube_end) begin
      hold_width_q  <= in_width_m1;
      hold_pos_c_q  <= in_pos_c;
      hold_last_w_q <= in_last_w;
      hold_last_h_q <= in_last_h;
      hold_last_c_q <= in_last_c;
    end
  end

  //////////////////////////////
  // lane and info drive
  //////////////////////////////

  always_comb begin
    lanes.shift_en = '0;
    if (step_normal) begin
      lanes.shift_en = NUM_LANES'(1) << in_pos_w;
    end else if (flush_step) begin
      lanes.shift_en = NUM_LANES'(1) << flush_pos_w_q;
    end
  end

  assign lanes.shift_data = in_data;
  assign lanes.zero_fill  = flush_q;
  assign lanes.clear_all  = flush_step & flush_last;

  assign info.step   = step_normal | flush_step;
  assign info.pos_w  = flush_q ? flush_pos_w_q : in_pos_w;
  assign info.width  = flush_q ? hold_width_q : in_width_m1;
  assign info.pos_c  = flush_q ? hold_pos_c_q : in_pos_c;
  // b_sync only marks the final flush beat
  assign info.b_sync = flush_q ? flush_last : in_b_sync;
  assign info.last_w = flush_q ? hold_last_w_q : in_last_w;
  assign info.last_h = flush_q ? hold_last_h_q : in_last_h;
  assign info.last_c = flush_q ? hold_last_c_q : in_last_c;

endmodule

// ==== design/cdp_bufferin_lane.sv ====
module cdp_bufferin_lane #(
  parameter int  TP      = 2,
  parameter int  BPE     = 9,
  parameter int  LANE_ID = 0,
  localparam int WIN     = 8 / TP + 1
) (
  input  logic                    nvdla_core_clk,
  input  logic                    nvdla_core_rstn,
  lane_shift_if.lane              shift,
  output logic [WIN*TP*BPE-1:0]   window
);

  localparam int SLOT_BITS = TP * BPE;

  // slot 0 is the newest, ascending range puts it in the msb position
  logic [0:WIN-1][SLOT_BITS-1:0] slot_q;
  logic [0:WIN-1][SLOT_BITS-1:0] slot_nxt;
  logic [SLOT_BITS-1:0]          new_slot;
  logic                          hit;

  assign hit      = shift.shift_en[LANE_ID];
  assign new_slot = shift.zero_fill ? '0 : shift.shift_data;

  // window as it stands after this step's shift
  always_comb begin
    slot_nxt = slot_q;
    if (hit) begin
      slot_nxt = {new_slot, slot_q[0:WIN-2]};
    end
  end

  // out samples the post-shift window on the same step
  assign window = slot_nxt;

  // clear wins over the last flush shift
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      slot_q <= '0;
    end else if (shift.clear_all) begin
      slot_q <= '0;
    end else if (hit) begin
      slot_q <= slot_nxt;
    end
  end

endmodule

// ==== design/cdp_bufferin_out.sv ====
module cdp_bufferin_out
  import cdp_bufferin_pkg::*;
#(
  parameter int  TP       = 2,
  parameter int  BPE      = 9,
  localparam int WIN      = 8 / TP + 1,
  localparam int WIN_BITS = WIN * TP * BPE
) (
  input  logic                                nvdla_core_clk,
  input  logic                                nvdla_core_rstn,
  input  logic [NUM_LANES-1:0][WIN_BITS-1:0]  windows,
  beat_info_if.out                            info,
  output logic                                out_free,
  output logic [WIN_BITS+INFO_BITS-1:0]       normalz_buf_data,
  output logic                                normalz_buf_data_pvld,
  input  logic                                normalz_buf_data_prdy
);

  localparam int LANE_SEL_BITS = $clog2(NUM_LANES);

  logic [LANE_SEL_BITS-1:0] lane_sel;
  logic [WIN_BITS-1:0]      win_sel;
  logic [INFO_BITS-1:0]     info_d;
  // output register
  logic                     pvld_q;
  logic [WIN_BITS-1:0]      data_q;
  logic [INFO_BITS-1:0]     info_q;

  //////////////////////////////
  // window select
  //////////////////////////////

  // pos_w never exceeds the lane count
  assign lane_sel = info.pos_w[LANE_SEL_BITS-1:0];
  assign win_sel  = windows[lane_sel];

  // pack info in the same layout as the input payload
  always_comb begin
    info_d = '0;
    info_d[POS_W_LSB +: POS_W_BITS] = info.pos_w;
    info_d[WIDTH_LSB +: WIDTH_BITS] = info.width;
    info_d[POS_C_LSB +: POS_C_BITS] = info.pos_c;
    info_d[B_SYNC_BIT]              = info.b_sync;
    info_d[LAST_W_BIT]              = info.last_w;
    info_d[LAST_H_BIT]              = info.last_h;
    info_d[LAST_C_BIT]              = info.last_c;
  end

  //////////////////////////////
  // output register
  //////////////////////////////

  // empty or being drained this cycle
  assign out_free = ~pvld_q | normalz_buf_data_prdy;

  // ctrl only steps when out_free is high
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      pvld_q <= 1'b0;
    end else if (info.step) begin
      pvld_q <= 1'b1;
    end else if (normalz_buf_data_prdy) begin
      pvld_q <= 1'b0;
    end
  end

  // held while pvld is up and prdy low
  always_ff @(posedge nvdla_core_clk) begin
    if (info.step) begin
      data_q <= win_sel;
      info_q <= info_d;
    end
  end

  assign normalz_buf_data      = {info_q, data_q};
  assign normalz_buf_data_pvld = pvld_q;

endmodule

// ==== design/cdp_bufferin_top.sv ====
module cdp_bufferin_top
  import cdp_bufferin_pkg::*;
#(
  parameter int  TP       = 2,
  parameter int  BPE      = 9,
  localparam int WIN      = 8 / TP + 1,
  localparam int WIN_BITS = WIN * TP * BPE
) (
  input  logic                           nvdla_core_clk,
  input  logic                           nvdla_core_rstn,
  input  logic [TP*BPE+INFO_BITS-1:0]    cdp_rdma2dp_pd,
  input  logic                           cdp_rdma2dp_valid,
  output logic                           cdp_rdma2dp_ready,
  output logic [WIN_BITS+INFO_BITS-1:0]  normalz_buf_data,
  output logic                           normalz_buf_data_pvld,
  input  logic                           normalz_buf_data_prdy
);

  // shift broadcast and per-step info
  lane_shift_if #(.TP(TP), .BPE(BPE)) lane_bus ();
  beat_info_if                        info_bus ();

  // post-shift window of every lane
  logic [NUM_LANES-1:0][WIN_BITS-1:0] lane_windows;
  logic                               out_free;

  cdp_bufferin_ctrl #(.TP(TP), .BPE(BPE)) u_ctrl (
    .nvdla_core_clk    (nvdla_core_clk),
    .nvdla_core_rstn   (nvdla_core_rstn),
    .cdp_rdma2dp_pd    (cdp_rdma2dp_pd),
    .cdp_rdma2dp_valid (cdp_rdma2dp_valid),
    .cdp_rdma2dp_ready (cdp_rdma2dp_ready),
    .out_free          (out_free),
    .lanes             (lane_bus.ctrl),
    .info              (info_bus.ctrl)
  );

  // one channel window per width position
  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    cdp_bufferin_lane #(.TP(TP), .BPE(BPE), .LANE_ID(g)) u_lane (
      .nvdla_core_clk  (nvdla_core_clk),
      .nvdla_core_rstn (nvdla_core_rstn),
      .shift           (lane_bus.lane),
      .window          (lane_windows[g])
    );
  end

  cdp_bufferin_out #(.TP(TP), .BPE(BPE)) u_out (
    .nvdla_core_clk        (nvdla_core_clk),
    .nvdla_core_rstn       (nvdla_core_rstn),
    .windows               (lane_windows),
    .info                  (info_bus.out),
    .out_free              (out_free),
    .normalz_buf_data      (normalz_buf_data),
    .normalz_buf_data_pvld (normalz_buf_data_pvld),
    .normalz_buf_data_prdy (normalz_buf_data_prdy)
  );

endmodule

// ==== verification/cdp_bufferin_tb_table.svh ====
// columns are data, pos_w, width, pos_c, flags {last_c last_h last_w b_sync},
// cube end and expected output info {last_c last_h last_w b_sync pos_c width-1 pos_w}

task automatic load_table();
  // cube one with width 2 and lane 1 first in the first group
  add_row(18'h0a101, 4'd1, 4'd2, 3'd0, 4'b0010, 1'b0, 15'h1011);
  add_row(18'h15100, 4'd0, 4'd2, 3'd0, 4'b0000, 1'b0, 15'h0010);
  add_row(18'h0a202, 4'd0, 4'd2, 3'd1, 4'b0000, 1'b0, 15'h0110);
  add_row(18'h35203, 4'd1, 4'd2, 3'd1, 4'b0010, 1'b0, 15'h1111);
  add_row(18'h2c304, 4'd0, 4'd2, 3'd2, 4'b0000, 1'b0, 15'h0210);
  add_row(18'h01305, 4'd1, 4'd2, 3'd2, 4'b0010, 1'b0, 15'h1211);
  // b_sync on the last group but last_w low so no flush yet
  add_row(18'h3f406, 4'd0, 4'd2, 3'd3, 4'b1101, 1'b0, 15'h6b10);
  // cube end followed by four flush beats
  add_row(18'h12407, 4'd1, 4'd2, 3'd3, 4'b1111, 1'b1, 15'h7b11);
  // cube two with width 3, lane 0 again right after the clear
  add_row(18'h1f0f0, 4'd0, 4'd3, 3'd0, 4'b0010, 1'b0, 15'h1020);
  add_row(18'h2e1e1, 4'd2, 4'd3, 3'd0, 4'b0000, 1'b0, 15'h0022);
  add_row(18'h3d2d2, 4'd2, 4'd3, 3'd1, 4'b0010, 1'b0, 15'h1122);
  add_row(18'h0c3c3, 4'd1, 4'd3, 3'd0, 4'b0000, 1'b0, 15'h0021);
  // cube end with six flush beats
  add_row(18'h15a5a, 4'd0, 4'd3, 3'd3, 4'b1111, 1'b1, 15'h7b20);
endtask

// ==== verification/cdp_bufferin_tb.sv ====
module cdp_bufferin_tb
  import cdp_bufferin_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TP           = 2;
  localparam int BPE          = 9;
  localparam int WIN          = 8 / TP + 1;
  localparam int FLUSH_ROUNDS = 4 / TP;
  localparam int SLOT_BITS    = TP * BPE;
  localparam int PD_BITS      = SLOT_BITS + INFO_BITS;
  localparam int OUT_BITS     = WIN * SLOT_BITS + INFO_BITS;
  localparam int TIMEOUT      = 200;

  logic                nvdla_core_clk;
  logic                nvdla_core_rstn;
  logic [PD_BITS-1:0]  cdp_rdma2dp_pd;
  logic                cdp_rdma2dp_valid;
  logic                cdp_rdma2dp_ready;
  logic [OUT_BITS-1:0] normalz_buf_data;
  logic                normalz_buf_data_pvld;
  logic                normalz_buf_data_prdy;

  // table rows packed as input payloads
  logic [PD_BITS-1:0]   row_pd[$];
  logic [INFO_BITS-1:0] row_info[$];
  bit                   row_end[$];
  // reference windows with slot 0 newest
  logic [SLOT_BITS-1:0] model_win[NUM_LANES][WIN];
  // expected output beats in order
  logic [OUT_BITS-1:0]  exp_q[$];
  string                exp_name[$];
  bit                   exp_mid_flush[$];
  int                   errors;
  int                   checks;
  int                   tests;
  int                   failed_tests;

  cdp_bufferin_top #(.TP(TP), .BPE(BPE)) dut (
    .nvdla_core_clk        (nvdla_core_clk),
    .nvdla_core_rstn       (nvdla_core_rstn),
    .cdp_rdma2dp_pd        (cdp_rdma2dp_pd),
    .cdp_rdma2dp_valid     (cdp_rdma2dp_valid),
    .cdp_rdma2dp_ready     (cdp_rdma2dp_ready),
    .normalz_buf_data      (normalz_buf_data),
    .normalz_buf_data_pvld (normalz_buf_data_pvld),
    .normalz_buf_data_prdy (normalz_buf_data_prdy)
  );

  `include "cdp_bufferin_tb_table.svh"

  always #20 nvdla_core_clk = ~nvdla_core_clk;

  // random back-pressure with about one stall in four cycles
  initial begin
    void'($urandom(32'h759e));
    forever begin
      @(posedge nvdla_core_clk);
      #2 normalz_buf_data_prdy = ($urandom_range(3) != 0);
    end
  end

  task automatic check_value(input string name, input logic [OUT_BITS-1:0] exp,
                             input logic [OUT_BITS-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Mismatch %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic close_test(input string name, input int base);
    tests++;
    if (errors != base) begin
      failed_tests++;
    end
    $display("%-20s %s", name, (errors == base) ? "pass" : "fail");
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout: %s", what);
    $display("SOME TESTS FAILED");
    $finish;
  endtask

  task automatic add_row(input logic [SLOT_BITS-1:0] data, input logic [3:0] pos_w,
                         input logic [3:0] width, input logic [2:0] pos_c,
                         input logic [3:0] flags, input bit cube_end,
                         input logic [INFO_BITS-1:0] exp_info);
    // input layout from the lsb is data pos_w width pos_c b_sync last_w last_h last_c
    row_pd.push_back({flags, pos_c, width, pos_w, data});
    row_info.push_back(exp_info);
    row_end.push_back(cube_end);
  endtask

  task automatic clear_model();
    for (int l = 0; l < NUM_LANES; l++) begin
      for (int s = 0; s < WIN; s++) begin
        model_win[l][s] = '0;
      end
    end
  endtask

  // shift one lane and queue the window it shows afterwards
  task automatic push_shift(input int lane, input logic [SLOT_BITS-1:0] word,
                            input logic [INFO_BITS-1:0] info, input string name,
                            input bit mid_flush);
    logic [OUT_BITS-1:0] beat;
    for (int s = WIN - 1; s > 0; s--) begin
      model_win[lane][s] = model_win[lane][s-1];
    end
    model_win[lane][0] = word;
    beat = '0;
    beat[WIN*SLOT_BITS +: INFO_BITS] = info;
    // newest slot in the most significant data position
    for (int s = 0; s < WIN; s++) begin
      beat[(WIN-1-s)*SLOT_BITS +: SLOT_BITS] = model_win[lane][s];
    end
    exp_q.push_back(beat);
    exp_name.push_back(name);
    exp_mid_flush.push_back(mid_flush);
  endtask

  task automatic build_expected();
    int lane;
    int w;
    int total;
    logic [INFO_BITS-1:0] info;
    clear_model();
    for (int r = 0; r < row_pd.size(); r++) begin
      lane = int'(row_pd[r][SLOT_BITS+POS_W_LSB +: POS_W_BITS]);
      push_shift(lane, row_pd[r][SLOT_BITS-1:0], row_info[r], $sformatf("row%0d", r), 1'b0);
      if (row_end[r]) begin
        // zeros swept over pos_w 0..width-1 for FLUSH_ROUNDS rounds
        w = int'(row_pd[r][SLOT_BITS+WIDTH_LSB +: WIDTH_BITS]);
        total = FLUSH_ROUNDS * w;
        for (int k = 0; k < total; k++) begin
          info = row_info[r];
          info[POS_W_LSB +: POS_W_BITS] = POS_W_BITS'(k % w);
          info[B_SYNC_BIT] = (k == total - 1);
          push_shift(k % w, '0, info, $sformatf("row%0d_flush%0d", r, k), k != total - 1);
        end
        clear_model();
      end
    end
  endtask

  task automatic drive_rows();
    int wait_cycles;
    for (int r = 0; r < row_pd.size(); r++) begin
      @(posedge nvdla_core_clk);
      #2;
      cdp_rdma2dp_pd    = row_pd[r];
      cdp_rdma2dp_valid = 1'b1;
      wait_cycles = 0;
      @(negedge nvdla_core_clk);
      // ready seen here means the beat transfers at the next rising edge
      while (!cdp_rdma2dp_ready) begin
        wait_cycles++;
        if (wait_cycles > TIMEOUT) begin
          stop_on_timeout($sformatf("input ready never rose for row %0d", r));
        end
        @(negedge nvdla_core_clk);
      end
    end
    @(posedge nvdla_core_clk);
    #2 cdp_rdma2dp_valid = 1'b0;
  endtask

  task automatic watch_output();
    int idle;
    int base;
    bit holding;
    logic [OUT_BITS-1:0] held;
    idle = 0;
    base = errors;
    holding = 1'b0;
    while (exp_q.size() > 0) begin
      @(negedge nvdla_core_clk);
      // a stalled beat must stay put
      if (holding) begin
        check_value({exp_name[0], "_hold_pvld"}, OUT_BITS'(1), OUT_BITS'(normalz_buf_data_pvld));
        check_value({exp_name[0], "_hold_data"}, held, normalz_buf_data);
      end
      holding = 1'b0;
      if (normalz_buf_data_pvld) begin
        idle = 0;
        // no new input while zeros are still being swept
        if (exp_mid_flush[0]) begin
          check_value({exp_name[0], "_ready"}, OUT_BITS'(0), OUT_BITS'(cdp_rdma2dp_ready));
        end
        if (normalz_buf_data_prdy) begin
          check_value(exp_name[0], exp_q[0], normalz_buf_data);
          close_test(exp_name[0], base);
          base = errors;
          void'(exp_q.pop_front());
          void'(exp_name.pop_front());
          void'(exp_mid_flush.pop_front());
        end else begin
          holding = 1'b1;
          held = normalz_buf_data;
        end
      end else begin
        idle++;
        if (idle > TIMEOUT) begin
          stop_on_timeout("expected output beat never appeared");
        end
      end
    end
  endtask

  initial begin
    int base;
    errors = 0;
    checks = 0;
    tests = 0;
    failed_tests = 0;
    nvdla_core_clk = 1'b0;
    nvdla_core_rstn = 1'b0;
    cdp_rdma2dp_pd = '0;
    cdp_rdma2dp_valid = 1'b0;
    normalz_buf_data_prdy = 1'b0;
    load_table();
    build_expected();

    //////////////////////////////
    // reset
    //////////////////////////////
    repeat (2) @(posedge nvdla_core_clk);
    #2 nvdla_core_rstn = 1'b1;
    @(negedge nvdla_core_clk);
    base = errors;
    check_value("reset_pvld", OUT_BITS'(0), OUT_BITS'(normalz_buf_data_pvld));
    check_value("reset_ready", OUT_BITS'(1), OUT_BITS'(cdp_rdma2dp_ready));
    close_test("reset", base);

    //////////////////////////////
    // streaming and flush
    //////////////////////////////
    fork
      drive_rows();
      watch_output();
    join

    // flush must not add beats beyond the swept count
    base = errors;
    repeat (8) begin
      @(negedge nvdla_core_clk);
      check_value("no_extra_beat", OUT_BITS'(0), OUT_BITS'(normalz_buf_data_pvld));
    end
    close_test("no_extra_beat", base);

    $display("tests %0d failed %0d checks %0d errors %0d", tests, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== cdp_bufferin.f ====
+incdir+verification
design/cdp_bufferin_pkg.sv
design/cdp_bufferin_if.sv
design/cdp_bufferin_ctrl.sv
design/cdp_bufferin_lane.sv
design/cdp_bufferin_out.sv
design/cdp_bufferin_top.sv
verification/cdp_bufferin_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module cdp_bufferin_tb \
  -f cdp_bufferin.f \
  -o cdp_bufferin_sim

sim_output=$(./obj_dir/cdp_bufferin_sim)
echo "$sim_output"

if echo "$sim_output" | grep -qx "ALL TESTS PASSED"; then
  exit 0
else
  exit 1
fi
